//--- sim.f
hw/sdramPkg.sv
hw/sdramReqIf.sv
hw/apbHostPort.sv
hw/refreshScheduler.sv
hw/sdramSequencer.sv
hw/sdramCtrl.sv
test/sdramModel.sv
test/tbSdramCtrl.sv

//--- Makefile
TOP = tbSdramCtrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- test/tbSdramCtrl.sv
module tbSdramCtrl import sdramPkg::*; ();

	localparam int InitTimeout = 1000;      // cycles from reset release to initDone
	localparam int XferTimeout = 200;       // room for a refresh ahead of the access
	localparam int RandCount   = 40;

	logic                Clock;
	logic                Reset_L;
	logic                pSel;
	logic                pEnable;
	logic                pWrite;
	logic [AddrBits-1:0] pAddr;
	logic [DataBits-1:0] pWData;
	logic [DataBits-1:0] pRData;
	logic                pReady;
	logic                initDone;
	logic                sdramCke;
	logic                sdramCsL;
	logic                sdramRasL;
	logic                sdramCasL;
	logic                sdramWeL;
	logic [RowBits-1:0]  sdramAddr;
	logic [BankBits-1:0] sdramBa;
	logic                sdramDqm;
	logic [DataBits-1:0] dqOut;
	logic                dqOe;
	logic [DataBits-1:0] dqIn;

	int                  checkCount;
	int                  errorCount;
	logic [31:0]         rngState;
	logic [DataBits-1:0] shadow [logic [AddrBits-1:0]];   // expected memory contents
	logic [AddrBits-1:0] addrList [RandCount];

	always #10 Clock = ~Clock;              // 20 unit period

	sdramCtrl #(
		.PowerUpCycles (200),
		.RefreshCycles (300)
	) i_sdramCtrl (
		.Clock (Clock), .Reset_L (Reset_L),
		.pSel (pSel), .pEnable (pEnable), .pWrite (pWrite), .pAddr (pAddr),
		.pWData (pWData), .pRData (pRData), .pReady (pReady), .initDone (initDone),
		.sdramCke (sdramCke), .sdramCsL (sdramCsL), .sdramRasL (sdramRasL),
		.sdramCasL (sdramCasL), .sdramWeL (sdramWeL), .sdramAddr (sdramAddr),
		.sdramBa (sdramBa), .sdramDqm (sdramDqm), .dqOut (dqOut), .dqOe (dqOe), .dqIn (dqIn)
	);

	sdramModel i_sdramModel (
		.Clock (Clock), .sdramCke (sdramCke), .sdramCsL (sdramCsL), .sdramRasL (sdramRasL),
		.sdramCasL (sdramCasL), .sdramWeL (sdramWeL), .sdramAddr (sdramAddr),
		.sdramBa (sdramBa), .sdramDqm (sdramDqm), .dqOut (dqOut), .dqOe (dqOe), .dqIn (dqIn)
	);

	//////////////////////////////
	// checks and helpers
	//////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("[FAIL] %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic checkTrue(input bit cond, input string what);
		checkCount++;
		assert (cond) else begin
			errorCount++;
			$display("%s", what);
		end
	endtask

	task automatic reportTest(input string name, input int startErr);
		$display("test %-14s done, %0d errors", name, errorCount - startErr);
	endtask

	// model state after an access must match the {bank, row, col} split of the address
	task automatic checkMapping(input logic [AddrBits-1:0] addr);
		checkValue("lastBank", 32'(i_sdramModel.lastBank), 32'(addr[AddrBits-1 -: BankBits]));
		checkValue("lastRow", 32'(i_sdramModel.lastRow), 32'(addr[ColBits +: RowBits]));
		checkValue("lastCol", 32'(i_sdramModel.lastCol), 32'(addr[ColBits-1:0]));
		checkTrue(i_sdramModel.lastAutoPre, "read or write issued without auto-precharge");
	endtask

	// called just after a falling edge, returns just after one
	task automatic apbTransfer(input bit wr, input logic [AddrBits-1:0] addr,
			input logic [DataBits-1:0] wData, input bit holdSel,
			output logic [DataBits-1:0] rData);
		int waited;
		waited  = 0;
		rData   = '0;
		pSel    = 1'b1;                     // setup phase
		pEnable = 1'b0;
		pWrite  = wr;
		pAddr   = addr;
		pWData  = wData;
		@(negedge Clock);
		pEnable = 1'b1;                     // access phase
		@(negedge Clock);
		while (!pReady && waited < XferTimeout) begin
			@(negedge Clock);
			waited++;
		end
		checkTrue(pReady, $sformatf("APB transfer to address %h got no pReady in %0d cycles",
			addr, XferTimeout));
		if (pReady) begin
			rData = pRData;
			@(negedge Clock);               // transfer completed on the edge just passed
			checkTrue(!pReady, "pReady stayed high for more than one cycle");
		end
		pEnable = 1'b0;
		pSel    = holdSel;
	endtask

	task automatic apbWrite(input logic [AddrBits-1:0] addr, input logic [DataBits-1:0] data,
			input bit holdSel = 1'b0);
		logic [DataBits-1:0] ignored;
		apbTransfer(1'b1, addr, data, holdSel, ignored);
	endtask

	task automatic apbRead(input logic [AddrBits-1:0] addr, output logic [DataBits-1:0] data,
			input bit holdSel = 1'b0);
		apbTransfer(1'b0, addr, '0, holdSel, data);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic testInit();
		int startErr;
		int waited;
		bit ckeSeen;
		bit readySeen;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] data;
		logic [DataBits-1:0] rd;
		startErr  = errorCount;
		ckeSeen   = 1'b0;
		readySeen = 1'b0;
		rngState  = xorshift32(rngState);
		addr      = rngState[AddrBits-1:0];
		rngState  = xorshift32(rngState);
		data      = rngState[DataBits-1:0];
		pSel      = 1'b1;                   // write posted during power up, has to wait
		pEnable   = 1'b0;
		pWrite    = 1'b1;
		pAddr     = addr;
		pWData    = data;
		repeat (150) begin
			@(negedge Clock);
			pEnable   = 1'b1;               // access phase from the second cycle on
			ckeSeen   = ckeSeen | sdramCke;
			readySeen = readySeen | pReady;
		end
		checkTrue(!ckeSeen, "sdramCke rose during the first 150 cycles");
		checkTrue(!readySeen, "pReady rose during the first 150 cycles");
		waited = 150;
		while (!initDone && waited < InitTimeout) begin
			@(negedge Clock);
			waited++;
		end
		checkTrue(initDone, $sformatf("initDone did not rise within %0d cycles", InitTimeout));
		checkValue("prechargeAllCount", 32'(i_sdramModel.prechargeAllCount), 32'd1);
		checkValue("refreshCount", 32'(i_sdramModel.refreshCount), 32'd8);
		// burst length 1 = 000, sequential = 0, cas latency 2 in bits 6:4
		checkValue("modeWord", 32'(i_sdramModel.modeWord), 32'd32);
		waited = 0;
		while (!pReady && waited < XferTimeout) begin
			@(negedge Clock);
			waited++;
		end
		checkTrue(pReady, "write posted during init got no pReady after initDone");
		if (pReady) begin
			@(negedge Clock);
			checkTrue(!pReady, "pReady stayed high for more than one cycle");
		end
		pEnable = 1'b0;
		pSel    = 1'b0;
		apbRead(addr, rd);
		checkValue("pRData", 32'(rd), 32'(data));
		reportTest("init", startErr);
	endtask

	task automatic testSingle();
		int startErr;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] data;
		logic [DataBits-1:0] rd;
		startErr = errorCount;
		rngState = xorshift32(rngState);
		addr     = rngState[AddrBits-1:0];
		rngState = xorshift32(rngState);
		data     = rngState[DataBits-1:0];
		apbWrite(addr, data);
		apbRead(addr, rd);
		checkValue("pRData", 32'(rd), 32'(data));
		reportTest("single access", startErr);
	endtask

	task automatic testMapping();
		int startErr;
		int b;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] data;
		logic [DataBits-1:0] rd;
		startErr = errorCount;
		for (b = 0; b < 4; b++) begin
			rngState = xorshift32(rngState);
			addr     = {BankBits'(b), rngState[RowBits+ColBits-1:0]};
			data     = rngState[31:16];
			apbWrite(addr, data);
			checkMapping(addr);
			apbRead(addr, rd);
			checkMapping(addr);
			checkValue("pRData", 32'(rd), 32'(data));
		end
		reportTest("address map", startErr);
	endtask

	task automatic testRandom();
		int startErr;
		int i;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] data;
		logic [DataBits-1:0] rd;
		startErr = errorCount;
		shadow.delete();
		for (i = 0; i < RandCount; i++) begin
			rngState = xorshift32(rngState);
			addr     = {BankBits'(i % 4), rngState[RowBits+ColBits-1:0]};
			rngState = xorshift32(rngState);
			data     = rngState[DataBits-1:0];
			apbWrite(addr, data);
			shadow[addr] = data;            // last write wins on a repeated address
			addrList[i]  = addr;
		end
		// stride 17 against 40 visits every entry once, out of order
		for (i = 0; i < RandCount; i++) begin
			addr = addrList[(i * 17) % RandCount];
			apbRead(addr, rd);
			checkValue("pRData", 32'(rd), 32'(shadow[addr]));
		end
		checkValue("orderErrors", 32'(i_sdramModel.orderErrors), 32'd0);
		reportTest("random traffic", startErr);
	endtask

	task automatic testRefresh();
		int startErr;
		int refStart;
		int errStart;
		int refDelta;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] rd;
		startErr = errorCount;
		refStart = i_sdramModel.refreshCount;
		errStart = i_sdramModel.orderErrors;
		repeat (1500) @(negedge Clock);
		addr = addrList[3];
		apbRead(addr, rd);                  // read in the middle of the idle window
		checkValue("pRData", 32'(rd), 32'(shadow[addr]));
		repeat (1500) @(negedge Clock);
		refDelta = i_sdramModel.refreshCount - refStart;
		checkTrue(refDelta >= 9 && refDelta <= 11,
			$sformatf("refresh count rose by %0d over 3000 cycles, not 9 to 11", refDelta));
		checkValue("orderErrors", 32'(i_sdramModel.orderErrors), 32'(errStart));
		reportTest("refresh", startErr);
	endtask

	task automatic testBackToBack();
		int startErr;
		int i;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] data;
		logic [DataBits-1:0] rd;
		startErr = errorCount;
		for (i = 0; i < 5; i++) begin
			rngState = xorshift32(rngState);
			addr     = rngState[AddrBits-1:0];
			rngState = xorshift32(rngState);
			data     = rngState[DataBits-1:0];
			apbWrite(addr, data, 1'b1);     // pSel stays high into the next setup
			apbRead(addr, rd, i < 4);
			checkValue("pRData", 32'(rd), 32'(data));
		end
		reportTest("back to back", startErr);
	endtask

	initial begin
		Clock      = 1'b0;
		Reset_L    = 1'b0;
		pSel       = 1'b0;
		pEnable    = 1'b0;
		pWrite     = 1'b0;
		pAddr      = '0;
		pWData     = '0;
		checkCount = 0;
		errorCount = 0;
		rngState   = 32'd53206;
		repeat (16) @(negedge Clock);
		Reset_L = 1'b1;
		testInit();
		testSingle();
		testMapping();
		testRandom();
		testRefresh();
		testBackToBack();
		checkValue("orderErrors", 32'(i_sdramModel.orderErrors), 32'd0);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- test/sdramModel.sv
module sdramModel import sdramPkg::*; (
	input  logic                Clock,
	input  logic                sdramCke,
	input  logic                sdramCsL,
	input  logic                sdramRasL,
	input  logic                sdramCasL,
	input  logic                sdramWeL,
	input  logic [RowBits-1:0]  sdramAddr,
	input  logic [BankBits-1:0] sdramBa,
	input  logic                sdramDqm,
	input  logic [DataBits-1:0] dqOut,
	input  logic                dqOe,
	output logic [DataBits-1:0] dqIn
);

	logic [DataBits-1:0]        mem [logic [AddrBits-1:0]];  // sparse, one word per {bank, row, col}
	logic [RowBits-1:0]         openRow [1 << BankBits];
	logic [(1 << BankBits)-1:0] rowOpen;
	logic [CasLatency-1:0][DataBits-1:0] dqPipe;            // read data on its way to the pins
	logic                       allClosed;                   // precharge-all seen since last activate
	logic [AddrBits-1:0]        wordAddr;
	sdramCmdE                   cmd;

	// state the testbench looks at
	logic [RowBits-1:0]         modeWord;
	logic [BankBits-1:0]        lastBank;
	logic [RowBits-1:0]         lastRow;
	logic [ColBits-1:0]         lastCol;
	logic                       lastAutoPre;
	int                         refreshCount;
	int                         prechargeAllCount;
	int                         orderErrors;

	assign cmd      = sdramCmdE'({sdramCsL, sdramRasL, sdramCasL, sdramWeL});
	assign wordAddr = {sdramBa, openRow[sdramBa], sdramAddr[ColBits-1:0]};
	assign dqIn     = dqPipe[CasLatency-1];               // valid on the cas latency edge

	task automatic flagError(input string what);
		orderErrors++;
		$display("sdram model error at time %0t: %s", $time, what);
	endtask

	initial begin
		rowOpen           = '0;
		allClosed         = 1'b0;
		modeWord          = '0;
		refreshCount      = 0;
		prechargeAllCount = 0;
		orderErrors       = 0;
		dqPipe           <= '0;
	end

	//////////////////////////////
	// command decode on the rising edge
	//////////////////////////////
	always @(posedge Clock) begin
		dqPipe <= {dqPipe[CasLatency-2:0], DataBits'(0)};   // idle bus reads zero
		if (sdramCke) begin
			case (cmd)
				activate: begin
					if (rowOpen[sdramBa])
						flagError("activate to a bank whose row is still open");
					openRow[sdramBa] = sdramAddr;
					rowOpen[sdramBa] = 1'b1;
					allClosed        = 1'b0;
					lastBank         = sdramBa;
					lastRow          = sdramAddr;
				end
				read, write: begin
					if (!rowOpen[sdramBa])
						flagError("read or write to a bank with no open row");
					lastBank    = sdramBa;
					lastCol     = sdramAddr[ColBits-1:0];
					lastAutoPre = sdramAddr[AutoPrechargeBit];
					if (cmd == write) begin
						if (!dqOe || sdramDqm)
							flagError("write command without driven and unmasked data");
						mem[wordAddr] = dqOut;
					end else begin
						dqPipe <= {dqPipe[CasLatency-2:0],
						           mem.exists(wordAddr) ? mem[wordAddr] : DataBits'(0)};
					end
					if (sdramAddr[AutoPrechargeBit])
						rowOpen[sdramBa] = 1'b0;              // row closes after the access
				end
				precharge: begin
					if (sdramAddr[AutoPrechargeBit]) begin
						rowOpen   = '0;
						allClosed = 1'b1;
						prechargeAllCount++;
					end else begin
						rowOpen[sdramBa] = 1'b0;
					end
				end
				autoRefresh: begin
					if (!allClosed || rowOpen != '0)
						flagError("auto refresh without a precharge-all before it");
					refreshCount++;
				end
				loadMode: modeWord = sdramAddr;
				default: ;                                    // nop and deselect
			endcase
		end
	end

endmodule

//--- hw/sdramCtrl.sv
module sdramCtrl import sdramPkg::*; #(
	parameter int PowerUpCycles = 4920,
	parameter int RefreshCycles = 375
) (
	input  logic                Clock,
	input  logic                Reset_L,
	// apb slave
	input  logic                pSel,
	input  logic                pEnable,
	input  logic                pWrite,
	input  logic [AddrBits-1:0] pAddr,
	input  logic [DataBits-1:0] pWData,
	output logic [DataBits-1:0] pRData,
	output logic                pReady,
	output logic                initDone,
	// sdram device
	output logic                sdramCke,
	output logic                sdramCsL,
	output logic                sdramRasL,
	output logic                sdramCasL,
	output logic                sdramWeL,
	output logic [RowBits-1:0]  sdramAddr,
	output logic [BankBits-1:0] sdramBa,
	output logic                sdramDqm,
	output logic [DataBits-1:0] dqOut,
	output logic                dqOe,
	input  logic [DataBits-1:0] dqIn
);

	logic refreshPending;          // scheduler asks for a refresh
	logic refreshAck;              // sequencer has taken it

	sdramReqIf reqBus ();          // host port to sequencer

	apbHostPort i_apbHostPort (
		.Clock   (Clock),
		.Reset_L (Reset_L),
		.pSel    (pSel),
		.pEnable (pEnable),
		.pWrite  (pWrite),
		.pAddr   (pAddr),
		.pWData  (pWData),
		.pRData  (pRData),
		.pReady  (pReady),
		.bus     (reqBus.host)
	);

	refreshScheduler #(
		.RefreshCycles (RefreshCycles)
	) i_refreshScheduler (
		.Clock          (Clock),
		.Reset_L        (Reset_L),
		.initDone       (initDone),
		.refreshAck     (refreshAck),
		.refreshPending (refreshPending)
	);

	sdramSequencer #(
		.PowerUpCycles (PowerUpCycles)
	) i_sdramSequencer (
		.Clock          (Clock),
		.Reset_L        (Reset_L),
		.bus            (reqBus.seq),
		.refreshPending (refreshPending),
		.refreshAck     (refreshAck),
		.initDone       (initDone),
		.sdramCke       (sdramCke),
		.sdramCsL       (sdramCsL),
		.sdramRasL      (sdramRasL),
		.sdramCasL      (sdramCasL),
		.sdramWeL       (sdramWeL),
		.sdramAddr      (sdramAddr),
		.sdramBa        (sdramBa),
		.sdramDqm       (sdramDqm),
		.dqOut          (dqOut),
		.dqOe           (dqOe),
		.dqIn           (dqIn)
	);

endmodule

//--- hw/sdramSequencer.sv
module sdramSequencer import sdramPkg::*; #(
	parameter int PowerUpCycles = 4920
) (
	input  logic                Clock,
	input  logic                Reset_L,
	sdramReqIf.seq              bus,
	input  logic                refreshPending,
	output logic                refreshAck,
	output logic                initDone,
	output logic                sdramCke,
	output logic                sdramCsL,
	output logic                sdramRasL,
	output logic                sdramCasL,
	output logic                sdramWeL,
	output logic [RowBits-1:0]  sdramAddr,
	output logic [BankBits-1:0] sdramBa,
	output logic                sdramDqm,
	output logic [DataBits-1:0] dqOut,
	output logic                dqOe,
	input  logic [DataBits-1:0] dqIn
);

	localparam int DelayBits  = $clog2(PowerUpCycles);       // longest wait is power up
	localparam int RefCntBits = $clog2(InitRefreshes);
	localparam logic [RowBits-1:0] PrechargeAllAddr = RowBits'(1) << AutoPrechargeBit;

	seqStateE             state, stateNext;
	seqStateE             retState, retNext;   // where waitDelay goes when the count hits zero
	logic [DelayBits-1:0] delayCnt;
	logic [DelayBits-1:0] delayVal;
	logic                 delayLoad;
	logic [RefCntBits-1:0] initRefCnt;        // init refreshes issued so far
	logic                 powerDone;          // cke is up for good
	logic [CasLatency:0]  rdPipe;             // read command travelling toward the sample edge

	sdramCmdE             cmdNext;
	logic [RowBits-1:0]   addrNext;
	logic [BankBits-1:0]  baNext;
	logic                 ckeNext;

	logic [BankBits-1:0]  reqBank;
	logic [RowBits-1:0]   reqRow;
	logic [ColBits-1:0]   reqCol;
	logic [RowBits-1:0]   colAddr;            // column plus auto precharge bit

	// cycles from the current state to the return state, minimum two
	function automatic logic [DelayBits-1:0] waitCount(input int cycles);
		return DelayBits'(cycles - 2);
	endfunction

	assign {reqBank, reqRow, reqCol} = bus.addr;

	always_comb begin
		colAddr                   = '0;
		colAddr[ColBits-1:0]      = reqCol;
		colAddr[AutoPrechargeBit] = 1'b1;  // close the row after the single word
	end

	assign refreshAck = (state == idle) && refreshPending;  // refresh wins over a request
	assign bus.done   = (state == finish);
	assign ckeNext    = powerDone || (state == firstNop);

	//////////////////////////////
	// next state and command
	//////////////////////////////
	always_comb begin
		stateNext = state;
		cmdNext   = nop;
		addrNext  = '0;
		baNext    = '0;
		delayLoad = 1'b0;
		delayVal  = '0;
		retNext   = retState;
		case (state)
			powerUp: begin
				cmdNext   = deselect;
				delayLoad = 1'b1;
				delayVal  = waitCount(PowerUpCycles);
				retNext   = firstNop;
				stateNext = waitDelay;
			end
			firstNop: stateNext = prechargeInit;
			prechargeInit: begin
				cmdNext   = precharge;
				addrNext  = PrechargeAllAddr;
				delayLoad = 1'b1;
				delayVal  = waitCount(TRp);
				retNext   = refreshInit;
				stateNext = waitDelay;
			end
			refreshInit: begin
				cmdNext   = autoRefresh;
				delayLoad = 1'b1;
				delayVal  = waitCount(TRfc);
				retNext   = (initRefCnt == RefCntBits'(InitRefreshes - 1)) ? loadModeReg
				                                                          : refreshInit;
				stateNext = waitDelay;
			end
			loadModeReg: begin
				cmdNext   = loadMode;
				addrNext  = ModeWord;                     // ba stays 0
				delayLoad = 1'b1;
				delayVal  = waitCount(TMrd);
				retNext   = idle;
				stateNext = waitDelay;
			end
			idle: begin
				if (refreshPending) begin
					stateNext = refreshPrecharge;
				end else if (bus.req) begin
					stateNext = activateRow;
				end
			end
			refreshPrecharge: begin
				cmdNext   = precharge;
				addrNext  = PrechargeAllAddr;
				delayLoad = 1'b1;
				delayVal  = waitCount(TRp);
				retNext   = refreshIssue;
				stateNext = waitDelay;
			end
			refreshIssue: begin
				cmdNext   = autoRefresh;
				delayLoad = 1'b1;
				delayVal  = waitCount(TRfc);
				retNext   = idle;
				stateNext = waitDelay;
			end
			activateRow: begin
				cmdNext   = activate;
				addrNext  = reqRow;
				baNext    = reqBank;
				delayLoad = 1'b1;
				delayVal  = waitCount(TRcd);
				retNext   = bus.write ? writeCmd : readCmd;
				stateNext = waitDelay;
			end
			readCmd: begin
				cmdNext   = read;
				addrNext  = colAddr;
				baNext    = reqBank;
				delayLoad = 1'b1;
				delayVal  = waitCount(CasLatency + TRp);  // data in, then row precharged
				retNext   = finish;
				stateNext = waitDelay;
			end
			writeCmd: begin
				cmdNext   = write;
				addrNext  = colAddr;
				baNext    = reqBank;
				delayLoad = 1'b1;
				delayVal  = waitCount(TRp + 1);           // write recovery plus precharge
				retNext   = finish;
				stateNext = waitDelay;
			end
			waitDelay: begin
				cmdNext = powerDone ? nop : deselect;    // nothing but deselect before cke
				if (delayCnt == '0)
					stateNext = retState;
			end
			finish: stateNext = idle;
			default: stateNext = powerUp;
		endcase
	end

	//////////////////////////////
	// control registers
	//////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state      <= powerUp;
			retState   <= powerUp;
			delayCnt   <= '0;
			initRefCnt <= '0;
			powerDone  <= 1'b0;
			rdPipe     <= '0;
		end else begin
			state    <= stateNext;
			retState <= retNext;
			if (delayLoad)
				delayCnt <= delayVal;
			else if (state == waitDelay && delayCnt != '0)
				delayCnt <= delayCnt - 1'b1;
			if (state == refreshInit)
				initRefCnt <= initRefCnt + 1'b1;
			if (state == firstNop)
				powerDone <= 1'b1;
			rdPipe <= {rdPipe[CasLatency-1:0], state == readCmd};
		end
	end

	// registered pins, one cycle behind the deciding state
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			sdramCke  <= 1'b0;
			{sdramCsL, sdramRasL, sdramCasL, sdramWeL} <= deselect;
			sdramAddr <= '0;
			sdramBa   <= '0;
			sdramDqm  <= 1'b1;
			dqOut     <= '0;
			dqOe      <= 1'b0;
			initDone  <= 1'b0;
		end else begin
			sdramCke  <= ckeNext;
			{sdramCsL, sdramRasL, sdramCasL, sdramWeL} <= cmdNext;
			sdramAddr <= addrNext;
			sdramBa   <= baNext;
			sdramDqm  <= !ckeNext;                      // both bytes live once clocked
			dqOut     <= (state == writeCmd) ? bus.wData : '0;
			dqOe      <= (state == writeCmd);           // drive only with the write command
			initDone  <= initDone || (state == idle);
		end
	end

	// read data is taken CasLatency edges after the device registers the read command
	always_ff @(posedge Clock) begin
		if (rdPipe[CasLatency])
			bus.rData <= dqIn;
	end

	// a clock-disabled device must see no real command
	ckeLowIdle: assert property (@(posedge Clock) disable iff (!Reset_L)
		!sdramCke |-> ({sdramCsL, sdramRasL, sdramCasL, sdramWeL} inside {nop, deselect}))
		else $error("command issued while sdramCke is low");

endmodule

//--- hw/refreshScheduler.sv
module refreshScheduler #(
	parameter int RefreshCycles = 375
) (
	input  logic Clock,
	input  logic Reset_L,
	input  logic initDone,
	input  logic refreshAck,
	output logic refreshPending
);

	localparam int CntBits = $clog2(RefreshCycles);          // holds RefreshCycles - 1

	logic [CntBits-1:0] count;     // cycles left in the current interval

	//////////////////////////////
	// interval counter
	//////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count          <= CntBits'(RefreshCycles - 1);
			refreshPending <= 1'b0;
		end else if (refreshAck) begin
			count          <= CntBits'(RefreshCycles - 1);  // new interval from the ack
			refreshPending <= 1'b0;
		end else if (initDone && !refreshPending) begin
			if (count == '0)
				refreshPending <= 1'b1;                       // held until the sequencer acks
			else
				count <= count - 1'b1;
		end
	end

	// the sequencer may only ack a refresh that was asked for
	ackNeedsPending: assert property (@(posedge Clock) disable iff (!Reset_L)
		refreshAck |-> refreshPending)
		else $error("refreshAck without refreshPending");

endmodule

//--- hw/apbHostPort.sv
module apbHostPort import sdramPkg::*; (
	input  logic                Clock,
	input  logic                Reset_L,
	input  logic                pSel,
	input  logic                pEnable,
	input  logic                pWrite,
	input  logic [AddrBits-1:0] pAddr,
	input  logic [DataBits-1:0] pWData,
	output logic [DataBits-1:0] pRData,
	output logic                pReady,
	sdramReqIf.host             bus
);

	logic accessStart;             // first access cycle of a transfer not yet served

	// req and pReady both block a restart while the same transfer is still in its access phase
	assign accessStart = pSel && pEnable && !bus.req && !pReady;

	//////////////////////////////
	// request and ready handshake
	//////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			bus.req <= 1'b0;
			pReady  <= 1'b0;
		end else begin
			pReady <= bus.done;        // ready lands the cycle after done
			if (accessStart)
				bus.req <= 1'b1;       // raise one cycle into the access phase
			else if (bus.done)
				bus.req <= 1'b0;       // drop right after completion
		end
	end

	// request fields, held stable until done
	always_ff @(posedge Clock) begin
		if (accessStart) begin
			bus.write <= pWrite;
			bus.addr  <= pAddr;
			bus.wData <= pWData;
		end
	end

	// read data latch, holds past the ready cycle
	always_ff @(posedge Clock) begin
		if (bus.done && !bus.write)
			pRData <= bus.rData;
	end

	// ready belongs to an access phase, so a host that drops pEnable early is caught here
	readyInAccess: assert property (@(posedge Clock) disable iff (!Reset_L)
		pReady |-> (pSel && pEnable))
		else $error("pReady outside an APB access phase");

endmodule

//--- hw/sdramReqIf.sv
interface sdramReqIf import sdramPkg::*; ();

	logic                req;      // held high until done
	logic                write;    // 1 = write, 0 = read
	logic [AddrBits-1:0] addr;     // word address {bank, row, col}
	logic [DataBits-1:0] wData;    // write data, stable while req
	logic [DataBits-1:0] rData;    // read data, valid in the done cycle
	logic                done;     // one cycle completion pulse

	// host side drives the request fields
	modport host (
		output req, write, addr, wData,
		input  rData, done
	);

	// sequencer side answers
	modport seq (
		input  req, write, addr, wData,
		output rData, done
	);

endinterface

//--- hw/sdramPkg.sv
package sdramPkg;

	//////////////////////////////
	// commands as {cs, ras, cas, we}, all active low
	//////////////////////////////
	typedef enum logic [3:0] {
		deselect    = 4'b1111,        // chip not selected
		nop         = 4'b0111,        // selected, no operation
		activate    = 4'b0011,        // open a row in a bank
		read        = 4'b0101,        // column read, a10 = auto precharge
		write       = 4'b0100,        // column write, a10 = auto precharge
		precharge   = 4'b0010,        // close rows, a10 = all banks
		autoRefresh = 4'b0001,        // cbr refresh
		loadMode    = 4'b0000         // mode register set
	} sdramCmdE;

	typedef enum logic [3:0] {
		powerUp,                      // cke low, waiting for supply and clock to settle
		firstNop,                     // cke goes high with a nop
		prechargeInit,                // precharge all before the init refreshes
		refreshInit,                  // one of the init auto refreshes
		loadModeReg,                  // program burst length and cas latency
		idle,                         // wait for refresh or host request
		refreshPrecharge,             // close all banks before a periodic refresh
		refreshIssue,                 // periodic auto refresh
		activateRow,                  // row open, not used as a resting state
		readCmd,                      // read with auto precharge
		writeCmd,                     // write with auto precharge
		waitDelay,                    // shared timed wait, then return state
		finish                        // access complete, done pulse
	} seqStateE;

	//////////////////////////////
	// address fields, host word address is {bank, row, col}
	//////////////////////////////
	localparam int BankBits = 2;
	localparam int RowBits  = 13;
	localparam int ColBits  = 10;
	localparam int AddrBits = BankBits + RowBits + ColBits;   // 25
	localparam int DataBits = 16;

	// device timing in clock cycles
	localparam int CasLatency    = 2;
	localparam int TRp           = 3;                         // precharge to next command
	localparam int TRcd          = 2;                         // activate to read or write
	localparam int TRfc          = 7;                         // refresh to next command
	localparam int TMrd          = 2;                         // mode load to next command
	localparam int InitRefreshes = 8;

	// burst length 1, sequential, cas latency 2
	localparam logic [RowBits-1:0] ModeWord = 13'd32;
	localparam int AutoPrechargeBit = 10;

endpackage
